//--- common/soc_map_pkg.sv
package soc_map_pkg;

    //============================================================
    // Program memory geometry
    //============================================================

    localparam int unsigned mem_size_bytes = 2048;

    // Byte address bits that reach the memory
    localparam int unsigned mem_addr_bits = $clog2(mem_size_bytes);

    // The memory is organized as 32-bit words with four byte lanes
    localparam int unsigned mem_words = mem_size_bytes / 4;

    typedef logic [mem_addr_bits-3:0] word_addr_t;

    // Hex image loaded at the bottom of memory
    localparam string mem_init_file = "program_ram/program_init.hex";

    //============================================================
    // Peripheral region
    //============================================================

    // Upper address nibble that selects the peripherals
    localparam logic [3:0] periph_region = 4'h8;

    // Only the low address bits are decoded inside the region
    localparam int unsigned periph_addr_bits = 12;

    typedef logic [periph_addr_bits-3:0] periph_reg_addr_t;

    // Register byte offsets
    localparam logic [periph_addr_bits-1:0] led_reg_offset    = 12'h000;
    localparam logic [periph_addr_bits-1:0] status_reg_offset = 12'h004;

    // LEDs on the board, driven active low
    localparam int unsigned led_count = 3;

endpackage

//--- common/soc_bus_pkg.sv
package soc_bus_pkg;

    import soc_map_pkg::*;

    //============================================================
    // CPU side buses
    //============================================================

    // Encoding follows the CPU data bus size field
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    // Instruction fetch request and reply
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } ibus_cmd_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
    } ibus_rsp_t;

    // Data access request, write data is lane replicated by the CPU
    typedef struct packed {
        logic         valid;
        logic         wr;
        logic [31:0]  address;
        logic [31:0]  data;
        access_size_t size;
    } dbus_cmd_t;

    // Only reads produce a reply
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } dbus_rsp_t;

    //============================================================
    // Internal ports
    //============================================================

    typedef struct packed {
        word_addr_t  word_addr;
        logic [3:0]  wr_be;
        logic [31:0] wdata;
    } ram_port_t;

    typedef struct packed {
        logic             sel;
        logic             wr;
        periph_reg_addr_t reg_addr;
        logic [31:0]      wdata;
    } periph_req_t;

endpackage

//--- program_ram/program_ram.sv
module program_ram
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
(
    input  logic        clk,

    input  ibus_cmd_t   ibus_cmd,
    output ibus_rsp_t   ibus_rsp,

    input  ram_port_t   ram_port,
    output logic [31:0] rdata
);

    // One 8-bit array per byte lane, which keeps RAM inference simple
    // for tools that handle byte enables poorly
    logic [7:0] lane_mem [4][mem_words];

    word_addr_t fetch_addr;

    assign fetch_addr = ibus_cmd.pc[mem_addr_bits-1:2];

    // The image holds whole words, split them over the lanes
    initial begin
        logic [31:0] init_image [mem_words];

        $readmemh(mem_init_file, init_image);
        for (int w = 0; w < mem_words; w++) begin
            for (int lane = 0; lane < 4; lane++) begin
                lane_mem[lane][w] = init_image[w][lane*8 +: 8];
            end
        end
    end

    //============================================================
    // Instruction fetch port
    //============================================================

    // Read only, returns the word as it stood before a same-cycle write
    always_ff @(posedge clk) begin
        ibus_rsp.valid <= ibus_cmd.valid;
        for (int lane = 0; lane < 4; lane++) begin
            ibus_rsp.inst[lane*8 +: 8] <= lane_mem[lane][fetch_addr];
        end
    end

    //============================================================
    // Data read/write port
    //============================================================

    // Written lanes return the new byte, the other lanes the stored one
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (ram_port.wr_be[lane]) begin
                lane_mem[lane][ram_port.word_addr] <= ram_port.wdata[lane*8 +: 8];
                rdata[lane*8 +: 8] <= ram_port.wdata[lane*8 +: 8];
            end else begin
                rdata[lane*8 +: 8] <= lane_mem[lane][ram_port.word_addr];
            end
        end
    end

endmodule

//--- led_status_regs/led_status_regs.sv
module led_status_regs
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    input  periph_req_t          periph_req,
    output logic [31:0]          rdata,

    input  logic                 button,
    output logic [led_count-1:0] leds
);

    logic       led_hit;
    logic       status_hit;
    logic       periph_rd;
    logic       periph_wr;
    logic [1:0] button_sync;

    //============================================================
    // Register decode
    //============================================================

    // Word offsets, the byte lane bits are not decoded
    assign led_hit    = (periph_req.reg_addr == led_reg_offset[periph_addr_bits-1:2]);
    assign status_hit = (periph_req.reg_addr == status_reg_offset[periph_addr_bits-1:2]);

    assign periph_wr = periph_req.sel && periph_req.wr;
    assign periph_rd = periph_req.sel && !periph_req.wr;

    //============================================================
    // LED register
    //============================================================

    // LEDs are active low, so a one in wdata lights the LED
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leds <= '1;
        end else if (periph_wr && led_hit) begin
            leds <= ~periph_req.wdata[led_count-1:0];
        end
    end

    //============================================================
    // Button synchronizer
    //============================================================

    // Two flops against metastability on the asynchronous button level
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            button_sync <= 2'b00;
        end else begin
            button_sync <= {button_sync[0], button};
        end
    end

    //============================================================
    // Read data
    //============================================================

    // No wait states: read data is ready the cycle after the request
    // Unmapped offsets keep the previous value
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdata <= '0;
        end else if (periph_rd) begin
            if (led_hit) begin
                rdata <= {{(32-led_count){1'b0}}, ~leds};
            end else if (status_hit) begin
                rdata <= {31'd0, button_sync[1]};
            end
        end
    end

endmodule

//--- verilog/dbus_router.sv
module dbus_router
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  dbus_cmd_t   dbus_cmd,
    output dbus_rsp_t   dbus_rsp,

    output ram_port_t   ram_port,
    input  logic [31:0] mem_rdata,

    output periph_req_t periph_req,
    input  logic [31:0] periph_rdata
);

    logic       periph_sel;
    logic       mem_wr;
    logic       rd_cmd;
    logic [3:0] byte_en;
    logic       mem_rd_done;
    logic       periph_rd_done;

    //============================================================
    // Region decode
    //============================================================

    assign periph_sel = dbus_cmd.valid && (dbus_cmd.address[31:28] == periph_region);

    // Writes anywhere with bit 31 set never reach the memory
    assign mem_wr = dbus_cmd.valid && dbus_cmd.wr && !dbus_cmd.address[31];
    assign rd_cmd = dbus_cmd.valid && !dbus_cmd.wr;

    //============================================================
    // Byte enables
    //============================================================

    always_comb begin
        case (dbus_cmd.size)
            size_byte: byte_en = 4'b0001 << dbus_cmd.address[1:0];
            size_half: byte_en = 4'b0011 << dbus_cmd.address[1:0];
            default:   byte_en = 4'b1111;
        endcase
    end

    // Data is already lane replicated, so it goes out unshifted
    assign ram_port.word_addr = dbus_cmd.address[mem_addr_bits-1:2];
    assign ram_port.wr_be     = {4{mem_wr}} & byte_en;
    assign ram_port.wdata     = dbus_cmd.data;

    assign periph_req.sel      = periph_sel;
    assign periph_req.wr       = dbus_cmd.wr;
    assign periph_req.reg_addr = dbus_cmd.address[periph_addr_bits-1:2];
    assign periph_req.wdata    = dbus_cmd.data;

    //============================================================
    // Read completion and response merge
    //============================================================

    // Both sources answer one cycle after the read command
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_rd_done    <= 1'b0;
            periph_rd_done <= 1'b0;
        end else begin
            mem_rd_done    <= rd_cmd && !periph_sel;
            periph_rd_done <= rd_cmd && periph_sel;
        end
    end

    assign dbus_rsp.valid = mem_rd_done || periph_rd_done;
    assign dbus_rsp.data  = periph_rd_done ? periph_rdata : mem_rdata;

endmodule

//--- verilog/soc_bus_top.sv
module soc_bus_top
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    input  ibus_cmd_t            ibus_cmd,
    output ibus_rsp_t            ibus_rsp,

    input  dbus_cmd_t            dbus_cmd,
    output dbus_rsp_t            dbus_rsp,

    input  logic                 button,
    output logic [led_count-1:0] leds
);

    ram_port_t   ram_port;
    logic [31:0] mem_rdata;
    periph_req_t periph_req;
    logic [31:0] periph_rdata;

    // Data bus decode and read merge
    dbus_router dbus_router_i (
        .clk          (clk),
        .reset        (reset),
        .dbus_cmd     (dbus_cmd),
        .dbus_rsp     (dbus_rsp),
        .ram_port     (ram_port),
        .mem_rdata    (mem_rdata),
        .periph_req   (periph_req),
        .periph_rdata (periph_rdata)
    );

    // Instruction bus goes straight to the fetch port
    program_ram program_ram_i (
        .clk      (clk),
        .ibus_cmd (ibus_cmd),
        .ibus_rsp (ibus_rsp),
        .ram_port (ram_port),
        .rdata    (mem_rdata)
    );

    led_status_regs led_status_regs_i (
        .clk        (clk),
        .reset      (reset),
        .periph_req (periph_req),
        .rdata      (periph_rdata),
        .button     (button),
        .leds       (leds)
    );

endmodule

//--- sim/soc_bus_checker.sv
module soc_bus_checker
    import soc_bus_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input dbus_cmd_t   dbus_cmd,
    input dbus_rsp_t   dbus_rsp,
    input ram_port_t   ram_port,
    input periph_req_t periph_req
);

    int unsigned assert_failures = 0;

    logic rd_cmd;
    logic wr_cmd;

    assign rd_cmd = dbus_cmd.valid && !dbus_cmd.wr;
    assign wr_cmd = dbus_cmd.valid && dbus_cmd.wr;

    //============================================================
    // Data bus response timing
    //============================================================

    // A response strobe is only legal right after a read
    rsp_follows_read: assert property (
        @(posedge clk) disable iff (reset) dbus_rsp.valid |-> $past(rd_cmd)
    ) else begin
        assert_failures++;
        $error("dbus_rsp.valid without a read in the previous cycle");
    end

    // Every read is answered exactly one cycle later
    read_gets_rsp: assert property (
        @(posedge clk) disable iff (reset) rd_cmd |=> dbus_rsp.valid
    ) else begin
        assert_failures++;
        $error("read command was not answered one cycle later");
    end

    no_rsp_after_write: assert property (
        @(posedge clk) disable iff (reset) wr_cmd |=> !dbus_rsp.valid
    ) else begin
        assert_failures++;
        $error("dbus_rsp.valid asserted after a write");
    end

    //============================================================
    // Region exclusion
    //============================================================

    no_mem_write_in_periph: assert property (
        @(posedge clk) disable iff (reset) periph_req.sel |-> (ram_port.wr_be == 4'b0000)
    ) else begin
        assert_failures++;
        $error("memory byte lane enabled during a peripheral access");
    end

endmodule

bind dbus_router soc_bus_checker router_checker_i (
    .clk        (clk),
    .reset      (reset),
    .dbus_cmd   (dbus_cmd),
    .dbus_rsp   (dbus_rsp),
    .ram_port   (ram_port),
    .periph_req (periph_req)
);

//--- sim/soc_bus_tb.sv
module soc_bus_tb
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
();

    typedef enum logic [2:0] {
        op_nop,
        op_fetch,
        op_mem_write,
        op_mem_read,
        op_led_write,
        op_periph_read,
        op_button
    } op_kind_t;

    typedef struct {
        op_kind_t     kind;
        logic [31:0]  address;
        access_size_t size;
        logic [31:0]  data;
        logic [31:0]  expected;
    } table_entry_t;

    localparam int unsigned reset_cycles = 10;

    logic                 clk;
    logic                 reset;
    logic                 button;
    ibus_cmd_t            ibus_cmd;
    ibus_rsp_t            ibus_rsp;
    dbus_cmd_t            dbus_cmd;
    dbus_rsp_t            dbus_rsp;
    logic [led_count-1:0] leds;

    table_entry_t         test_table[$];
    logic [31:0]          ref_mem [mem_words];
    logic [led_count-1:0] model_leds;
    ibus_rsp_t            exp_ibus;
    dbus_rsp_t            exp_dbus;
    logic [31:0]          lfsr_state;
    int unsigned          cycle_count = 0;
    int unsigned          cycle_limit = 1000;

    soc_bus_top soc_bus_top_i (
        .clk      (clk),
        .reset    (reset),
        .ibus_cmd (ibus_cmd),
        .ibus_rsp (ibus_rsp),
        .dbus_cmd (dbus_cmd),
        .dbus_rsp (dbus_rsp),
        .button   (button),
        .leds     (leds)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "simulation ran past its cycle limit");
        end
    end

    //============================================================
    // Random data and reference model
    //============================================================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_random_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // The CPU replicates narrow data over all lanes
    task automatic random_lane_data(input access_size_t size, output logic [31:0] data);
        case (size)
            size_byte: begin
                take_random_bits(8, data);
                data = {4{data[7:0]}};
            end
            size_half: begin
                take_random_bits(16, data);
                data = {2{data[15:0]}};
            end
            default: take_random_bits(32, data);
        endcase
    endtask

    function automatic logic [3:0] lane_mask(input access_size_t size, input logic [1:0] offset);
        logic [3:0] mask;
        mask = '0;
        for (int lane = 0; lane < 4; lane++) begin
            case (size)
                size_byte: mask[lane] = (lane == offset);
                size_half: mask[lane] = (lane == offset) || (lane == offset + 1);
                default:   mask[lane] = 1'b1;
            endcase
        end
        return mask;
    endfunction

    task automatic model_write(input logic [31:0] address, input access_size_t size,
                               input logic [31:0] data);
        logic [3:0] mask;
        word_addr_t word_index;
        mask = lane_mask(size, address[1:0]);
        word_index = address[mem_addr_bits-1:2];
        for (int lane = 0; lane < 4; lane++) begin
            if (mask[lane]) begin
                ref_mem[word_index][lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
    endtask

    //============================================================
    // Compare tasks
    //============================================================

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failed check");
    endtask

    // Data is only compared while a response is expected
    task automatic check_ibus(input ibus_rsp_t expected, input ibus_rsp_t actual);
        if (expected.valid) begin
            if (actual !== expected) begin
                stop_on_failure($sformatf("error: ibus_rsp expected %h got %h",
                                          expected, actual));
            end
        end else if (actual.valid !== 1'b0) begin
            stop_on_failure($sformatf("error: ibus_rsp.valid expected %h got %h",
                                      1'b0, actual.valid));
        end
    endtask

    task automatic check_dbus(input dbus_rsp_t expected, input dbus_rsp_t actual);
        if (expected.valid) begin
            if (actual !== expected) begin
                stop_on_failure($sformatf("error: dbus_rsp expected %h got %h",
                                          expected, actual));
            end
        end else if (actual.valid !== 1'b0) begin
            stop_on_failure($sformatf("error: dbus_rsp.valid expected %h got %h",
                                      1'b0, actual.valid));
        end
    endtask

    task automatic check_leds(input logic [led_count-1:0] expected,
                              input logic [led_count-1:0] actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("error: leds expected %h got %h", expected, actual));
        end
    endtask

    //============================================================
    // Stimulus table
    //============================================================

    task automatic add_entry(input op_kind_t kind, input logic [31:0] address,
                             input access_size_t size, input logic [31:0] data,
                             input logic [31:0] expected);
        table_entry_t e;
        e.kind = kind;
        e.address = address;
        e.size = size;
        e.data = data;
        e.expected = expected;
        test_table.push_back(e);
    endtask

    task automatic build_table();
        // Idle after reset
        repeat (3) add_entry(op_nop, 0, size_word, 0, 0);
        // Back-to-back fetches over the whole image
        for (int w = 0; w < 16; w++) begin
            add_entry(op_fetch, w * 4, size_word, 0, 0);
        end
        add_entry(op_nop, 0, size_word, 0, 0);
        add_entry(op_mem_read, 32'h0000_0008, size_word, 0, 0);
        // Words, halfwords and bytes at every lane offset
        add_entry(op_mem_write, 32'h0000_0100, size_word, 0, 0);
        add_entry(op_mem_read,  32'h0000_0100, size_word, 0, 0);
        add_entry(op_mem_write, 32'h0000_0104, size_word, 0, 0);
        add_entry(op_mem_write, 32'h0000_0104, size_half, 0, 0);
        add_entry(op_mem_write, 32'h0000_0106, size_half, 0, 0);
        add_entry(op_mem_read,  32'h0000_0104, size_word, 0, 0);
        add_entry(op_mem_write, 32'h0000_0108, size_word, 0, 0);
        for (int b = 0; b < 4; b++) begin
            add_entry(op_mem_write, 32'h0000_0108 + b, size_byte, 0, 0);
            add_entry(op_mem_read,  32'h0000_0108, size_word, 0, 0);
        end
        add_entry(op_mem_write, 32'h0000_010c, size_word, 0, 0);
        add_entry(op_mem_write, 32'h0000_010d, size_byte, 0, 0);
        add_entry(op_mem_write, 32'h0000_010e, size_half, 0, 0);
        add_entry(op_nop, 0, size_word, 0, 0);
        add_entry(op_mem_read,  32'h0000_010c, size_word, 0, 0);
        // Data write seen by the fetch port
        add_entry(op_mem_write, 32'h0000_0020, size_word, 0, 0);
        add_entry(op_fetch,     32'h0000_0020, size_word, 0, 0);
        add_entry(op_mem_read,  32'h0000_0020, size_word, 0, 0);
        // Expected holds the active-low leds after each LED register write
        add_entry(op_led_write,   32'h8000_0000, size_word, 32'h0000_0005, 32'h2);
        add_entry(op_periph_read, 32'h8000_0000, size_word, 0, 32'h0000_0005);
        add_entry(op_led_write,   32'h8000_0000, size_word, 32'h0000_0002, 32'h5);
        add_entry(op_periph_read, 32'h8000_0000, size_word, 0, 32'h0000_0002);
        add_entry(op_led_write,   32'h8000_0000, size_word, 32'hffff_fff8, 32'h7);
        add_entry(op_periph_read, 32'h8000_0000, size_word, 0, 32'h0000_0000);
        // Status register for both button levels
        add_entry(op_button, 0, size_word, 32'h1, 0);
        repeat (3) add_entry(op_nop, 0, size_word, 0, 0);
        add_entry(op_periph_read, 32'h8000_0004, size_word, 0, 32'h0000_0001);
        add_entry(op_button, 0, size_word, 32'h0, 0);
        repeat (3) add_entry(op_nop, 0, size_word, 0, 0);
        add_entry(op_periph_read, 32'h8000_0004, size_word, 0, 32'h0000_0000);
        repeat (2) add_entry(op_nop, 0, size_word, 0, 0);
    endtask

    task automatic send_dbus(input logic wr, input logic [31:0] address,
                             input logic [31:0] data, input access_size_t size);
        dbus_cmd.valid = 1'b1;
        dbus_cmd.wr = wr;
        dbus_cmd.address = address;
        dbus_cmd.data = data;
        dbus_cmd.size = size;
    endtask

    task automatic apply_entry(input table_entry_t e);
        logic [31:0] wdata;
        word_addr_t  word_index;
        ibus_cmd = '0;
        dbus_cmd = '0;
        exp_ibus = '0;
        exp_dbus = '0;
        word_index = e.address[mem_addr_bits-1:2];
        case (e.kind)
            op_fetch: begin
                ibus_cmd.valid = 1'b1;
                ibus_cmd.pc = e.address;
                exp_ibus.valid = 1'b1;
                exp_ibus.inst = ref_mem[word_index];
            end
            op_mem_write: begin
                random_lane_data(e.size, wdata);
                send_dbus(1'b1, e.address, wdata, e.size);
                model_write(e.address, e.size, wdata);
            end
            op_mem_read: begin
                send_dbus(1'b0, e.address, '0, size_word);
                exp_dbus.valid = 1'b1;
                exp_dbus.data = ref_mem[word_index];
            end
            op_led_write: begin
                send_dbus(1'b1, e.address, e.data, size_word);
                model_leds = e.expected[led_count-1:0];
            end
            op_periph_read: begin
                send_dbus(1'b0, e.address, '0, size_word);
                exp_dbus.valid = 1'b1;
                exp_dbus.data = e.expected;
            end
            op_button: button = e.data[0];
            default: ;
        endcase
    endtask

    //============================================================
    // Main sequence
    //============================================================

    initial begin
        ibus_cmd = '0;
        dbus_cmd = '0;
        button = 1'b0;
        reset = 1'b1;
        lfsr_state = 32'hdc35;
        model_leds = '1;
        exp_ibus = '0;
        exp_dbus = '0;
        $readmemh(mem_init_file, ref_mem);
        build_table();
        cycle_limit = reset_cycles + 8 * test_table.size() + 50;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Responses of each entry are checked before the next one is driven
        foreach (test_table[i]) begin
            @(negedge clk);
            check_ibus(exp_ibus, ibus_rsp);
            check_dbus(exp_dbus, dbus_rsp);
            check_leds(model_leds, leds);
            apply_entry(test_table[i]);
        end
        @(negedge clk);
        check_ibus(exp_ibus, ibus_rsp);
        check_dbus(exp_dbus, dbus_rsp);
        check_leds(model_leds, leds);

        if (soc_bus_top_i.dbus_router_i.router_checker_i.assert_failures == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "assertions in the data bus checker failed");
        end
    end

endmodule

//--- program_ram/program_init.hex
// Program image loaded from word address 0 upward
// One column: a 32-bit instruction word in hex per line
00000093
80000137
00500193
00312023
00412203
00127213
fe020ce3
00108093
0010f093
00112023
00100293
00200313
00300393
00400413
ff1ff06f
0000006f

//--- all.f
common/soc_map_pkg.sv
common/soc_bus_pkg.sv
program_ram/program_ram.sv
led_status_regs/led_status_regs.sv
verilog/dbus_router.sv
verilog/soc_bus_top.sv
sim/soc_bus_checker.sv
sim/soc_bus_tb.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  # Packages first, the bus types depend on the address map
  - common/soc_map_pkg.sv
  - common/soc_bus_pkg.sv
  - program_ram/program_ram.sv
  - led_status_regs/led_status_regs.sv
  - verilog/dbus_router.sv
  - verilog/soc_bus_top.sv
  - target: simulation
    files:
      - sim/soc_bus_checker.sv
      - sim/soc_bus_tb.sv
